/* verilog/noc_params.svh */
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// flit payload width.
`define NOC_DATA_WIDTH 32

// length field, held in the low bits of a header payload.
`define NOC_LEN_WIDTH 12

// entries per input queue.
`define NOC_QUEUE_DEPTH 8

`endif

/* verilog/nocPkg.sv */
package nocPkg;

  // kind of flit, travels beside the payload.
  typedef enum logic [2:0] {
    flitIdle = 3'd0,
    flitHead = 3'd1,
    flitBody = 3'd2,
    flitTail = 3'd3
  } flitIdT;

  // one-hot arbiter state, bit 0 is idle.
  typedef enum logic [5:0] {
    grIdle = 6'b000001,
    grL    = 6'b000010,
    grN    = 6'b000100,
    grE    = 6'b001000,
    grW    = 6'b010000,
    grS    = 6'b100000
  } grantT;

  typedef enum logic [2:0] {
    portL = 3'd0,
    portN = 3'd1,
    portE = 3'd2,
    portW = 3'd3,
    portS = 3'd4
  } portIdxT;

endpackage

/* verilog/flitDecoder.sv */
`timescale 1ns/100ps
`include "noc_params.svh"

module flitDecoder (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       inValid,
  input  nocPkg::flitIdT             inId,
  input  logic [`NOC_DATA_WIDTH-1:0] inData,
  output logic                       inReady,
  input  logic                       pop,
  output logic                       req,
  output nocPkg::flitIdT             headId,
  output logic [`NOC_DATA_WIDTH-1:0] headData,
  output logic [`NOC_LEN_WIDTH-1:0]  headLen,
  output logic                       headIsHead
);
  localparam int Depth = `NOC_QUEUE_DEPTH;
  localparam int PtrWidth = $clog2(Depth);
  localparam int CountWidth = $clog2(Depth + 1);

  nocPkg::flitIdT             idMem [Depth];
  logic [`NOC_DATA_WIDTH-1:0] dataMem [Depth];
  logic [PtrWidth-1:0]        wrPtr;
  logic [PtrWidth-1:0]        rdPtr;
  logic [CountWidth-1:0]      count;
  logic                       wrEn;
  logic                       rdEn;

  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign inReady = (count != CountWidth'(Depth));
  assign req = (count != '0);
  assign wrEn = inValid && inReady;
  assign rdEn = pop && req;  // never pop an empty queue.

  always_ff @(posedge clk)
  begin
    if (wrEn)
    begin
      idMem[wrPtr] <= inId;
      dataMem[wrPtr] <= inData;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (wrEn)
        wrPtr <= nextPtr(wrPtr);
      if (rdEn)
        rdPtr <= nextPtr(rdPtr);
      // write and pop together leave the count alone.
      case ({wrEn, rdEn})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign headId = req ? idMem[rdPtr] : nocPkg::flitIdle;
  assign headData = dataMem[rdPtr];
  assign headLen = headData[`NOC_LEN_WIDTH-1:0];
  assign headIsHead = (headId == nocPkg::flitHead);
endmodule

/* verilog/packetTimer.sv */
`timescale 1ns/100ps
`include "noc_params.svh"

module packetTimer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      load,
  input  logic [`NOC_LEN_WIDTH-1:0] len,
  input  logic                      run,
  output logic                      timesUp
);
  logic [`NOC_LEN_WIDTH-1:0] limit;
  logic [`NOC_LEN_WIDTH-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (load)
        limit <= len;  // header at the head of the queue.
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // a holder sees limit+1 granted cycles before this rises.
  assign timesUp = (count == limit);
endmodule

/* verilog/outputArbiter.sv */
`timescale 1ns/100ps
`include "noc_params.svh"

module outputArbiter (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      reqL, reqN, reqE, reqW, reqS,
  input  logic                      headIsHeadL, headIsHeadN, headIsHeadE,
  input  logic                      headIsHeadW, headIsHeadS,
  input  logic [`NOC_LEN_WIDTH-1:0] headLenL, headLenN, headLenE, headLenW, headLenS,
  output nocPkg::grantT             grant
);
  localparam int NumPorts = 5;

  nocPkg::grantT       state;
  nocPkg::grantT       nextState;
  logic [NumPorts-1:0] reqVec;
  logic [NumPorts-1:0] timesUp;
  logic [NumPorts-1:0] runTimer;

  assign reqVec = {reqS, reqW, reqE, reqN, reqL};
  assign grant = state;

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocPkg::grIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    logic        found;
    int unsigned holder;
    int unsigned start;
    int unsigned span;
    int unsigned idx;

    nextState = nocPkg::grIdle;
    runTimer = '0;
    found = 1'b0;
    holder = 0;
    start = 0;
    span = 0;

    for (int p = 0; p < NumPorts; p++)
      if (state[p+1])
        holder = p;

    if (state == nocPkg::grIdle)
    begin
      span = NumPorts;  // fixed order L, N, E, W, S.
    end
    else if (reqVec[holder] && !timesUp[holder])
    begin
      runTimer[holder] = 1'b1;
      nextState = state;
      found = 1'b1;
    end
    else
    begin
      start = holder + 1;  // rotate past the holder.
      span = NumPorts - 1;
    end

    for (int k = 0; k < NumPorts; k++)
    begin
      idx = start + k;
      if (idx >= NumPorts)
        idx = idx - NumPorts;
      if (!found && k < span && reqVec[idx])
      begin
        nextState = nocPkg::grantT'(6'b000010 << idx);
        found = 1'b1;
      end
    end
  end

  packetTimer timerL (
    .clk(clk), .rst(rst), .load(headIsHeadL), .len(headLenL),
    .run(runTimer[0]), .timesUp(timesUp[0])
  );

  packetTimer timerN (
    .clk(clk), .rst(rst), .load(headIsHeadN), .len(headLenN),
    .run(runTimer[1]), .timesUp(timesUp[1])
  );

  packetTimer timerE (
    .clk(clk), .rst(rst), .load(headIsHeadE), .len(headLenE),
    .run(runTimer[2]), .timesUp(timesUp[2])
  );

  packetTimer timerW (
    .clk(clk), .rst(rst), .load(headIsHeadW), .len(headLenW),
    .run(runTimer[3]), .timesUp(timesUp[3])
  );

  packetTimer timerS (
    .clk(clk), .rst(rst), .load(headIsHeadS), .len(headLenS),
    .run(runTimer[4]), .timesUp(timesUp[4])
  );
endmodule

/* verilog/outputSwitch.sv */
`timescale 1ns/100ps
`include "noc_params.svh"

module outputSwitch (
  input  logic                       clk,
  input  logic                       rst,
  input  nocPkg::grantT              grant,
  input  logic                       reqL, reqN, reqE, reqW, reqS,
  input  nocPkg::flitIdT             headIdL, headIdN, headIdE, headIdW, headIdS,
  input  logic [`NOC_DATA_WIDTH-1:0] headDataL, headDataN, headDataE, headDataW, headDataS,
  output logic                       popL, popN, popE, popW, popS,
  output logic                       outValid,
  output nocPkg::flitIdT             outId,
  output logic [`NOC_DATA_WIDTH-1:0] outData,
  output nocPkg::portIdxT            outSrc
);
  logic [4:0]                 popVec;
  nocPkg::flitIdT             idArr [5];
  logic [`NOC_DATA_WIDTH-1:0] dataArr [5];
  nocPkg::portIdxT            selIdx;

  assign popVec = grant[5:1] & {reqS, reqW, reqE, reqN, reqL};
  assign {popS, popW, popE, popN, popL} = popVec;

  assign idArr = '{headIdL, headIdN, headIdE, headIdW, headIdS};
  assign dataArr = '{headDataL, headDataN, headDataE, headDataW, headDataS};

  // grant is one-hot, so at most one pop bit is set.
  always_comb
  begin
    selIdx = nocPkg::portL;
    for (int p = 0; p < 5; p++)
      if (popVec[p])
        selIdx = nocPkg::portIdxT'(p);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |popVec;
  end

  always_ff @(posedge clk)
  begin
    if (|popVec)
    begin
      outId <= idArr[selIdx];
      outData <= dataArr[selIdx];
      outSrc <= selIdx;  // source tag.
    end
  end
endmodule

/* verilog/routerOutputPort.sv */
`timescale 1ns/100ps
`include "noc_params.svh"

module routerOutputPort (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       inValidL, inValidN, inValidE, inValidW, inValidS,
  input  nocPkg::flitIdT             inIdL, inIdN, inIdE, inIdW, inIdS,
  input  logic [`NOC_DATA_WIDTH-1:0] inDataL, inDataN, inDataE, inDataW, inDataS,
  output logic                       inReadyL, inReadyN, inReadyE, inReadyW, inReadyS,
  output logic                       outValid,
  output nocPkg::flitIdT             outId,
  output logic [`NOC_DATA_WIDTH-1:0] outData,
  output nocPkg::portIdxT            outSrc
);
  logic                       reqL, reqN, reqE, reqW, reqS;
  logic                       popL, popN, popE, popW, popS;
  nocPkg::flitIdT             headIdL, headIdN, headIdE, headIdW, headIdS;
  logic [`NOC_DATA_WIDTH-1:0] headDataL, headDataN, headDataE, headDataW, headDataS;
  logic [`NOC_LEN_WIDTH-1:0]  headLenL, headLenN, headLenE, headLenW, headLenS;
  logic                       headIsHeadL, headIsHeadN, headIsHeadE, headIsHeadW, headIsHeadS;
  nocPkg::grantT              grant;

  flitDecoder decL (
    .clk(clk), .rst(rst), .inValid(inValidL), .inId(inIdL), .inData(inDataL),
    .inReady(inReadyL), .pop(popL), .req(reqL), .headId(headIdL), .headData(headDataL),
    .headLen(headLenL), .headIsHead(headIsHeadL)
  );

  flitDecoder decN (
    .clk(clk), .rst(rst), .inValid(inValidN), .inId(inIdN), .inData(inDataN),
    .inReady(inReadyN), .pop(popN), .req(reqN), .headId(headIdN), .headData(headDataN),
    .headLen(headLenN), .headIsHead(headIsHeadN)
  );

  flitDecoder decE (
    .clk(clk), .rst(rst), .inValid(inValidE), .inId(inIdE), .inData(inDataE),
    .inReady(inReadyE), .pop(popE), .req(reqE), .headId(headIdE), .headData(headDataE),
    .headLen(headLenE), .headIsHead(headIsHeadE)
  );

  flitDecoder decW (
    .clk(clk), .rst(rst), .inValid(inValidW), .inId(inIdW), .inData(inDataW),
    .inReady(inReadyW), .pop(popW), .req(reqW), .headId(headIdW), .headData(headDataW),
    .headLen(headLenW), .headIsHead(headIsHeadW)
  );

  flitDecoder decS (
    .clk(clk), .rst(rst), .inValid(inValidS), .inId(inIdS), .inData(inDataS),
    .inReady(inReadyS), .pop(popS), .req(reqS), .headId(headIdS), .headData(headDataS),
    .headLen(headLenS), .headIsHead(headIsHeadS)
  );

  outputArbiter arb (
    .clk(clk), .rst(rst),
    .reqL(reqL), .reqN(reqN), .reqE(reqE), .reqW(reqW), .reqS(reqS),
    .headIsHeadL(headIsHeadL), .headIsHeadN(headIsHeadN), .headIsHeadE(headIsHeadE),
    .headIsHeadW(headIsHeadW), .headIsHeadS(headIsHeadS),
    .headLenL(headLenL), .headLenN(headLenN), .headLenE(headLenE),
    .headLenW(headLenW), .headLenS(headLenS),
    .grant(grant)
  );

  outputSwitch sw (
    .clk(clk), .rst(rst), .grant(grant),
    .reqL(reqL), .reqN(reqN), .reqE(reqE), .reqW(reqW), .reqS(reqS),
    .headIdL(headIdL), .headIdN(headIdN), .headIdE(headIdE),
    .headIdW(headIdW), .headIdS(headIdS),
    .headDataL(headDataL), .headDataN(headDataN), .headDataE(headDataE),
    .headDataW(headDataW), .headDataS(headDataS),
    .popL(popL), .popN(popN), .popE(popE), .popW(popW), .popS(popS),
    .outValid(outValid), .outId(outId), .outData(outData), .outSrc(outSrc)
  );
endmodule

/* verification/routerOutputPort_tb.sv */
`timescale 1ns/100ps
`include "noc_params.svh"

module routerOutputPort_tb;
  localparam int NumRows = 11;
  localparam int StallLimit = 64;
  localparam int DrainLimit = 200;

  typedef struct packed {
    int              scen;
    nocPkg::portIdxT port;
    int              flits;
    int              len;    // declared length in the header.
    int              delay;  // cycles before the first flit is offered.
    logic [7:0]      tag;    // data seed, top byte of every payload.
  } rowT;

  logic                       clk;
  logic                       rst;
  logic [4:0]                 inValid;
  logic [4:0]                 inReady;
  nocPkg::flitIdT             inId [5];
  logic [`NOC_DATA_WIDTH-1:0] inData [5];
  logic                       outValid;
  nocPkg::flitIdT             outId;
  logic [`NOC_DATA_WIDTH-1:0] outData;
  nocPkg::portIdxT            outSrc;

  rowT                        rows [NumRows];
  integer                     seed;
  int                         startAt [5];
  logic [`NOC_DATA_WIDTH+2:0] sendQ [5][$];  // {id, data} still to offer.
  logic [`NOC_DATA_WIDTH+2:0] expQ [5][$];   // per-port scoreboard.
  nocPkg::portIdxT            expSrc [$];    // expected source order.

  routerOutputPort uut (
    .clk(clk), .rst(rst),
    .inValidL(inValid[0]), .inValidN(inValid[1]), .inValidE(inValid[2]),
    .inValidW(inValid[3]), .inValidS(inValid[4]),
    .inIdL(inId[0]), .inIdN(inId[1]), .inIdE(inId[2]), .inIdW(inId[3]), .inIdS(inId[4]),
    .inDataL(inData[0]), .inDataN(inData[1]), .inDataE(inData[2]),
    .inDataW(inData[3]), .inDataS(inData[4]),
    .inReadyL(inReady[0]), .inReadyN(inReady[1]), .inReadyE(inReady[2]),
    .inReadyW(inReady[3]), .inReadyS(inReady[4]),
    .outValid(outValid), .outId(outId), .outData(outData), .outSrc(outSrc)
  );

  always #4 clk = ~clk;

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic checkBit(input string name, input logic expV, input logic actV);
    if (actV !== expV)
      failRun($sformatf("Mismatch at %0t ns: %s expected %b, actual %b",
        $time, name, expV, actV));
  endtask

  task automatic checkFlitId(input string name, input nocPkg::flitIdT expV,
    input nocPkg::flitIdT actV);
    if (actV !== expV)
      failRun($sformatf("Mismatch at %0t ns: %s expected %0d, actual %0d",
        $time, name, expV, actV));
  endtask

  task automatic checkData(input string name, input logic [`NOC_DATA_WIDTH-1:0] expV,
    input logic [`NOC_DATA_WIDTH-1:0] actV);
    if (actV !== expV)
      failRun($sformatf("Mismatch at %0t ns: %s expected %h, actual %h",
        $time, name, expV, actV));
  endtask

  task automatic checkSrc(input string name, input nocPkg::portIdxT expV,
    input nocPkg::portIdxT actV);
    if (actV !== expV)
      failRun($sformatf("Mismatch at %0t ns: %s expected %0d, actual %0d",
        $time, name, expV, actV));
  endtask

  task automatic fillTable();
    rows[0] = '{0, nocPkg::portN, 5, 4, 0, 8'hA1};  // single packet.
    // all five ports start together.
    rows[1] = '{1, nocPkg::portL, 4, 3, 0, 8'hB0};
    rows[2] = '{1, nocPkg::portN, 3, 2, 0, 8'hB1};
    rows[3] = '{1, nocPkg::portE, 5, 4, 0, 8'hB2};
    rows[4] = '{1, nocPkg::portW, 2, 1, 0, 8'hB3};
    rows[5] = '{1, nocPkg::portS, 4, 3, 0, 8'hB4};
    // E first, then L and W queue up behind it.
    rows[6] = '{2, nocPkg::portE, 4, 3, 0, 8'hC2};
    rows[7] = '{2, nocPkg::portL, 3, 2, 1, 8'hC0};
    rows[8] = '{2, nocPkg::portW, 3, 2, 1, 8'hC3};
    // S declares fewer flits than it sends.
    rows[9] = '{3, nocPkg::portS, 6, 2, 0, 8'hD4};
    rows[10] = '{3, nocPkg::portL, 3, 2, 1, 8'hD0};
  endtask

  task automatic loadScenario(input int scen);
    logic [`NOC_DATA_WIDTH-1:0] d;
    nocPkg::flitIdT             id;
    int                         p;
    for (int r = 0; r < NumRows; r++)
      if (rows[r].scen == scen)
      begin
        p = int'(rows[r].port);
        startAt[p] = rows[r].delay;
        for (int i = 0; i < rows[r].flits; i++)
        begin
          d = {rows[r].tag, (`NOC_DATA_WIDTH-8)'($random(seed))};
          if (i == 0)
          begin
            id = nocPkg::flitHead;
            d[`NOC_LEN_WIDTH-1:0] = rows[r].len[`NOC_LEN_WIDTH-1:0];
          end
          else if (i == rows[r].flits - 1)
            id = nocPkg::flitTail;
          else
            id = nocPkg::flitBody;
          sendQ[p].push_back({id, d});
          expQ[p].push_back({id, d});
        end
      end
  endtask

  // packet-level model of the rotating-priority grant order.
  task automatic buildOrder(input int scen);
    int rem [5];
    int budget [5];
    int arrive [5];
    int holder;
    int t;
    int pick;
    int idx;
    int n;
    for (int p = 0; p < 5; p++)
    begin
      rem[p] = 0;
      budget[p] = 0;
      arrive[p] = 0;
    end
    for (int r = 0; r < NumRows; r++)
      if (rows[r].scen == scen)
      begin
        rem[int'(rows[r].port)] = rows[r].flits;
        budget[int'(rows[r].port)] = rows[r].len + 1;  // at most length+1 per grant.
        arrive[int'(rows[r].port)] = rows[r].delay;
      end
    holder = -1;
    t = 0;
    while (rem[0] + rem[1] + rem[2] + rem[3] + rem[4] > 0)
    begin
      pick = -1;
      if (holder >= 0)
        for (int k = 1; k < 5; k++)
        begin
          idx = (holder + k) % 5;
          if (pick < 0 && rem[idx] > 0 && arrive[idx] <= t)
            pick = idx;
        end
      // idle search in order L, N, E, W, S.
      for (int k = 0; k < 5; k++)
        if (pick < 0 && rem[k] > 0 && arrive[k] <= t)
          pick = k;
      if (pick < 0)
      begin
        holder = -1;
        t = t + 1;
      end
      else
      begin
        n = (rem[pick] < budget[pick]) ? rem[pick] : budget[pick];
        repeat (n) expSrc.push_back(nocPkg::portIdxT'(pick));
        rem[pick] = rem[pick] - n;
        t = t + n;
        holder = pick;
      end
    end
  endtask

  task automatic feedPorts();
    logic [`NOC_DATA_WIDTH+2:0] flit;
    int                         t;
    int                         busy;
    int                         stall [5];
    for (int p = 0; p < 5; p++)
      stall[p] = 0;
    t = 0;
    busy = 1;
    while (busy != 0)
    begin
      @(posedge clk);
      #1;
      busy = 0;
      for (int p = 0; p < 5; p++)
      begin
        inValid[p] = 1'b0;
        if (sendQ[p].size() > 0 && t >= startAt[p])
        begin
          if (inReady[p])
          begin
            flit = sendQ[p].pop_front();
            inId[p] = nocPkg::flitIdT'(flit[`NOC_DATA_WIDTH+2:`NOC_DATA_WIDTH]);
            inData[p] = flit[`NOC_DATA_WIDTH-1:0];
            inValid[p] = 1'b1;
            stall[p] = 0;
          end
          else
          begin
            stall[p] = stall[p] + 1;
            if (stall[p] > StallLimit)
              failRun($sformatf("port %0d stayed full and never took its flit", p));
          end
        end
        if (sendQ[p].size() > 0 || inValid[p])
          busy = 1;
      end
      t = t + 1;
    end
  endtask

  task automatic drainWait();
    int waited;
    waited = 0;
    while (expSrc.size() > 0)
    begin
      @(posedge clk);
      waited = waited + 1;
      if (waited > DrainLimit)
        failRun("the output stopped before all expected flits came out");
    end
    repeat (6) @(posedge clk);  // quiet gap, stray flits show up here.
  endtask

  always @(negedge clk)
  begin
    logic [`NOC_DATA_WIDTH+2:0] flit;
    nocPkg::portIdxT            src;
    if (!rst && outValid)
    begin
      if (expSrc.size() == 0)
        failRun("outValid went high with no flit left to expect");
      src = expSrc.pop_front();
      checkSrc("outSrc", src, outSrc);
      flit = expQ[int'(src)].pop_front();
      checkFlitId("outId", nocPkg::flitIdT'(flit[`NOC_DATA_WIDTH+2:`NOC_DATA_WIDTH]), outId);
      checkData("outData", flit[`NOC_DATA_WIDTH-1:0], outData);
    end
  end

  initial
  begin
    int leftover;
    seed = 32'h5303;
    clk = 1'b0;
    rst = 1'b1;
    inValid = '0;
    for (int p = 0; p < 5; p++)
    begin
      inId[p] = nocPkg::flitIdle;
      inData[p] = '0;
    end
    fillTable();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    checkBit("outValid", 1'b0, outValid);
    for (int p = 0; p < 5; p++)
      checkBit($sformatf("inReady[%0d]", p), 1'b1, inReady[p]);
    for (int s = 0; s < 4; s++)
    begin
      loadScenario(s);
      buildOrder(s);
      feedPorts();
      drainWait();
    end
    leftover = 0;
    for (int p = 0; p < 5; p++)
      leftover = leftover + expQ[p].size();
    if (leftover == 0)
    begin
      $display("TESTS PASSED");
      $finish;
    end
    else
      failRun($sformatf("%0d flits never reached the output", leftover));
  end
endmodule

/* files.f */
+incdir+verilog
verilog/nocPkg.sv
verilog/flitDecoder.sv
verilog/packetTimer.sv
verilog/outputArbiter.sv
verilog/outputSwitch.sv
verilog/routerOutputPort.sv
verification/routerOutputPort_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the router output port testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -Wno-fatal --timescale 1ns/100ps \
  --top-module routerOutputPort_tb -f files.f -o simv
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
